//--- hdl/usb_pkg.sv
`default_nettype none

package usb_pkg;

  localparam int ADDR_BITS = 7;
  localparam int ENDP_BITS = 4;

  // Two-bit packet kind, the meaning depends on the packet class
  typedef logic [1:0] pid_t;

  localparam pid_t TOK_OUT = 2'b00;
  localparam pid_t TOK_SOF = 2'b01;
  localparam pid_t TOK_IN = 2'b10;
  localparam pid_t TOK_SETUP = 2'b11;

  localparam pid_t HSK_ACK = 2'b00;
  localparam pid_t HSK_NAK = 2'b10;

  localparam pid_t DATA0 = 2'b00;
  localparam pid_t DATA1 = 2'b10;

  // Packet class codes for the encoder sideband
  localparam logic [1:0] CLS_HSK = 2'd2;
  localparam logic [1:0] CLS_DATA = 2'd3;

  typedef struct packed {
    pid_t       pid;
    logic [1:0] kind;
  } tuser_t;

endpackage

`default_nettype wire

//--- hdl/xact_pkg.sv
`default_nettype none

package xact_pkg;

  typedef enum logic [1:0] {
    IDLE,
    BULK,
    DUMP
  } xact_state_t;

  typedef enum logic [2:0] {
    BLK_IDLE,
    DATI_TX,
    DATI_ZDP,
    DATI_ACK,
    DATO_RX,
    DATO_ERR,
    DATO_ACK,
    BLK_DONE
  } bulk_state_t;

  typedef enum logic [2:0] {
    ER_NONE = 3'h0,
    ER_TOKN = 3'h3,
    ER_ENDP = 3'h5
  } err_code_t;

  // Cycles from packet start to end of packet
  localparam int EOP_DELAY = 5;

  // Host response limit in clock cycles
  localparam int TURNAROUND_DEFAULT = 255;

endpackage

`default_nettype wire

//--- hdl/xact_control.sv
`timescale 1ns/10ps
`default_nettype none

module xact_control #(
  parameter int BULK_ENDPOINT = 1
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [usb_pkg::ADDR_BITS-1:0] usb_addr_i,
  input  logic                          tok_recv_i,
  input  usb_pkg::pid_t                 tok_pid_i,
  input  logic [usb_pkg::ADDR_BITS-1:0] tok_addr_i,
  input  logic [usb_pkg::ENDP_BITS-1:0] tok_endp_i,
  input  logic                          hsk_recv_i,
  input  logic                          hsk_sent_i,
  input  logic                          usb_recv_i,
  input  logic                          usb_sent_i,
  input  logic                          rx_last_i,
  input  logic                          blk_in_ready_i,
  input  logic                          blk_out_ready_i,
  input  logic                          timeout_i,
  output xact_pkg::bulk_state_t         bulk_state_o,
  output xact_pkg::err_code_t           err_code_o,
  output logic                          blk_start_o,
  output logic                          blk_fetch_o,
  output logic                          blk_store_o,
  output logic                          device_idle_o
);
  import usb_pkg::*;
  import xact_pkg::*;

  xact_state_t state_q;
  logic        tok_ours;
  logic        dir_in_q;

  assign tok_ours = tok_recv_i && tok_addr_i == usb_addr_i;

  assign blk_start_o = state_q == BULK && bulk_state_o == BLK_IDLE;
  assign device_idle_o = state_q == IDLE || bulk_state_o == BLK_DONE;

  // Transaction FSM, picks up tokens addressed to this device
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      err_code_o <= ER_NONE;
    end else begin
      case (state_q)
        IDLE: begin
          if (tok_ours && (tok_pid_i == TOK_IN || tok_pid_i == TOK_OUT)) begin
            state_q <= BULK;
            err_code_o <= tok_endp_i != ENDP_BITS'(BULK_ENDPOINT) ? ER_ENDP : ER_NONE;
          end else if (tok_ours) begin
            state_q <= DUMP;
            err_code_o <= ER_TOKN;
          end else begin
            err_code_o <= ER_NONE;
          end
        end
        BULK: begin
          if (bulk_state_o == BLK_DONE) begin
            state_q <= IDLE;
          end
        end
        // Unsupported token, stays here until reset
        default: state_q <= DUMP;
      endcase
    end
  end

  // Direction of the accepted token
  always_ff @(posedge clock) begin
    if (tok_ours && state_q == IDLE) begin
      dir_in_q <= tok_pid_i == TOK_IN;
    end
  end

  // Bulk FSM, only runs inside a bulk transaction
  always_ff @(posedge clock) begin
    if (reset || state_q != BULK) begin
      bulk_state_o <= BLK_IDLE;
      blk_fetch_o <= 1'b0;
      blk_store_o <= 1'b0;
    end else begin
      case (bulk_state_o)
        BLK_IDLE: begin
          if (dir_in_q) begin
            bulk_state_o <= blk_in_ready_i ? DATI_TX : DATI_ZDP;
            blk_fetch_o <= blk_in_ready_i;
          end else begin
            bulk_state_o <= blk_out_ready_i ? DATO_RX : DATO_ERR;
            blk_store_o <= blk_out_ready_i;
          end
        end
        DATI_TX, DATI_ZDP: begin
          if (usb_sent_i) begin
            bulk_state_o <= DATI_ACK;
          end
        end
        DATI_ACK: begin
          // Anything other than a handshake also ends the wait
          if (hsk_recv_i || timeout_i || tok_recv_i || usb_recv_i) begin
            bulk_state_o <= BLK_DONE;
          end
        end
        DATO_RX, DATO_ERR: begin
          if (rx_last_i) begin
            bulk_state_o <= DATO_ACK;
          end
        end
        DATO_ACK: begin
          if (hsk_sent_i) begin
            bulk_state_o <= BLK_DONE;
          end
        end
        default: begin
          blk_fetch_o <= 1'b0;
          blk_store_o <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/data_toggle.sv
`timescale 1ns/10ps
`default_nettype none

module data_toggle #(
  parameter int NUM_ENDPOINTS = 4
) (
  input  logic                          clock,
  input  logic                          reset,
  input  xact_pkg::bulk_state_t         bulk_state_i,
  input  logic                          tok_recv_i,
  input  usb_pkg::pid_t                 tok_pid_i,
  input  logic [usb_pkg::ENDP_BITS-1:0] tok_endp_i,
  input  logic                          hsk_recv_i,
  input  usb_pkg::pid_t                 hsk_pid_i,
  input  logic                          hsk_sent_i,
  input  logic                          eop_rx_i,
  input  logic                          hsk_pending_i,
  output usb_pkg::tuser_t               usb_tuser_o
);
  import usb_pkg::*;
  import xact_pkg::*;

  localparam int IW = NUM_ENDPOINTS > 1 ? $clog2(NUM_ENDPOINTS) : 1;

  logic [NUM_ENDPOINTS-1:0] odd_q;
  logic [IW-1:0]            endp_q;
  logic                     endp_ok_q;
  logic                     tok_start;
  logic                     tok_odd;
  logic                     flip;

  assign tok_start = tok_recv_i && bulk_state_i == BLK_IDLE;
  assign tok_odd = tok_endp_i < NUM_ENDPOINTS && odd_q[tok_endp_i[IW-1:0]];

  // ACK sent for OUT data, or ACK received for IN data
  assign flip = endp_ok_q && (hsk_sent_i && bulk_state_i == DATO_ACK ||
                              hsk_recv_i && hsk_pid_i == HSK_ACK && bulk_state_i == DATI_ACK);

  always_ff @(posedge clock) begin
    if (reset) begin
      endp_ok_q <= 1'b0;
    end else if (tok_start) begin
      endp_ok_q <= tok_endp_i < NUM_ENDPOINTS;
    end
  end

  always_ff @(posedge clock) begin
    if (tok_start) begin
      endp_q <= tok_endp_i[IW-1:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      odd_q <= '0;
    end else if (flip) begin
      odd_q[endp_q] <= ~odd_q[endp_q];
    end
  end

  // Packet type for the encoder
  always_ff @(posedge clock) begin
    if (reset) begin
      usb_tuser_o <= '0;
    end else if (eop_rx_i && !hsk_pending_i) begin
      usb_tuser_o <= tuser_t'{pid: HSK_ACK, kind: CLS_HSK};
    end else if (tok_start && tok_pid_i == TOK_IN) begin
      usb_tuser_o <= tuser_t'{pid: tok_odd ? DATA1 : DATA0, kind: CLS_DATA};
    end
  end

endmodule

`default_nettype wire

//--- hdl/eop_timer.sv
`timescale 1ns/10ps
`default_nettype none

module eop_timer (
  input  logic clock,
  input  logic reset,
  input  logic usb_recv_i,
  input  logic usb_sent_i,
  input  logic hsk_sent_i,
  output logic eop_rx_o,
  output logic eop_tx_o,
  output logic hsk_send_o
);
  import xact_pkg::*;

  localparam int CW = $clog2(EOP_DELAY + 1);

  logic [1:0]         start;
  logic [1:0][CW-1:0] count_q;
  logic [1:0]         eop_q;

  // Channel 0 for received packets, channel 1 for sent packets
  assign start = {usb_sent_i, usb_recv_i};
  assign eop_rx_o = eop_q[0];
  assign eop_tx_o = eop_q[1];

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
      eop_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (start[i]) begin
          count_q[i] <= CW'(EOP_DELAY);
        end else if (count_q[i] != '0) begin
          count_q[i] <= count_q[i] - 1'b1;
        end
        eop_q[i] <= count_q[i] == CW'(1);
      end
    end
  end

  // Handshake request, held until the encoder has sent it
  always_ff @(posedge clock) begin
    if (reset || hsk_sent_i) begin
      hsk_send_o <= 1'b0;
    end else if (eop_q[0]) begin
      hsk_send_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/turnaround_timer.sv
`timescale 1ns/10ps
`default_nettype none

module turnaround_timer #(
  parameter int TURNAROUND_CYCLES = xact_pkg::TURNAROUND_DEFAULT
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  input  logic response_i,
  input  logic device_idle_i,
  output logic timeout_o
);

  localparam int CW = $clog2(TURNAROUND_CYCLES + 1);

  logic [CW-1:0] count_q;
  logic          active_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
      active_q <= 1'b0;
      timeout_o <= 1'b0;
    end else if (start_i) begin
      count_q <= CW'(TURNAROUND_CYCLES);
      active_q <= 1'b1;
      timeout_o <= 1'b0;
    end else if (response_i) begin
      active_q <= 1'b0;
      timeout_o <= 1'b0;
    end else if (active_q) begin
      // Terminal count
      if (count_q == CW'(1)) begin
        active_q <= 1'b0;
        timeout_o <= 1'b1;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end else if (device_idle_i) begin
      timeout_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/tx_stream_path.sv
`timescale 1ns/10ps
`default_nettype none

module tx_stream_path (
  input  logic                  clock,
  input  logic                  reset,
  input  xact_pkg::bulk_state_t bulk_state_i,
  input  logic                  blk_tvalid_i,
  input  logic                  blk_tlast_i,
  input  logic                  blk_tkeep_i,
  input  logic [7:0]            blk_tdata_i,
  output logic                  blk_tready_o,
  output logic                  usb_tvalid_o,
  input  logic                  usb_tready_i,
  output logic                  usb_tlast_o,
  output logic                  usb_tkeep_o,
  output logic [7:0]            usb_tdata_o
);
  import xact_pkg::*;

  logic       sel_blk;
  logic       sel_valid;
  logic [9:0] sel_data;
  logic       zdp_done_q;
  logic       spare_valid_q;
  logic [9:0] spare_data_q;
  logic [9:0] main_data_q;
  logic       in_ready;
  logic       in_fire;
  logic       main_free;

  // Bulk source, or a single zero-data item
  assign sel_blk = bulk_state_i == DATI_TX;
  assign sel_valid = sel_blk ? blk_tvalid_i : bulk_state_i == DATI_ZDP && !zdp_done_q;
  assign sel_data = sel_blk ? {blk_tkeep_i, blk_tlast_i, blk_tdata_i} : {1'b0, 1'b1, 8'h00};

  assign in_ready = !spare_valid_q;
  assign in_fire = sel_valid && in_ready;
  assign main_free = !usb_tvalid_o || usb_tready_i;
  assign blk_tready_o = in_ready && sel_blk;

  assign {usb_tkeep_o, usb_tlast_o, usb_tdata_o} = main_data_q;

  always_ff @(posedge clock) begin
    if (reset || bulk_state_i != DATI_ZDP) begin
      zdp_done_q <= 1'b0;
    end else if (in_fire) begin
      zdp_done_q <= 1'b1;
    end
  end

  // Skid register, main stage plus one spare
  always_ff @(posedge clock) begin
    if (reset) begin
      usb_tvalid_o <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (main_free) begin
      usb_tvalid_o <= spare_valid_q || in_fire;
      spare_valid_q <= 1'b0;
    end else if (in_fire) begin
      spare_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (main_free) begin
      main_data_q <= spare_valid_q ? spare_data_q : sel_data;
    end else if (in_fire) begin
      spare_data_q <= sel_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/xact_top.sv
`timescale 1ns/10ps
`default_nettype none

module xact_top #(
  parameter int BULK_ENDPOINT = 1,
  parameter int NUM_ENDPOINTS = 4,
  parameter int TURNAROUND_CYCLES = xact_pkg::TURNAROUND_DEFAULT
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [usb_pkg::ADDR_BITS-1:0] usb_addr_i,
  // Decoded tokens and handshakes
  input  logic                          tok_recv_i,
  input  usb_pkg::pid_t                 tok_pid_i,
  input  logic [usb_pkg::ADDR_BITS-1:0] tok_addr_i,
  input  logic [usb_pkg::ENDP_BITS-1:0] tok_endp_i,
  input  logic                          hsk_recv_i,
  input  usb_pkg::pid_t                 hsk_pid_i,
  output logic                          hsk_send_o,
  input  logic                          hsk_sent_i,
  input  logic                          usb_recv_i,
  input  logic                          usb_sent_i,
  output usb_pkg::tuser_t               usb_tuser_o,
  // OUT data from the decoder
  input  logic                          usb_rx_tvalid_i,
  output logic                          usb_rx_tready_o,
  input  logic                          usb_rx_tlast_i,
  input  logic                          usb_rx_tkeep_i,
  input  logic [7:0]                    usb_rx_tdata_i,
  // IN data to the encoder
  output logic                          usb_tx_tvalid_o,
  input  logic                          usb_tx_tready_i,
  output logic                          usb_tx_tlast_o,
  output logic                          usb_tx_tkeep_o,
  output logic [7:0]                    usb_tx_tdata_o,
  // Bulk sink and source
  output logic                          blk_rx_tvalid_o,
  input  logic                          blk_rx_tready_i,
  output logic                          blk_rx_tlast_o,
  output logic                          blk_rx_tkeep_o,
  output logic [7:0]                    blk_rx_tdata_o,
  input  logic                          blk_tx_tvalid_i,
  output logic                          blk_tx_tready_o,
  input  logic                          blk_tx_tlast_i,
  input  logic                          blk_tx_tkeep_i,
  input  logic [7:0]                    blk_tx_tdata_i,
  input  logic                          blk_in_ready_i,
  input  logic                          blk_out_ready_i,
  output logic                          blk_start_o,
  output logic                          blk_fetch_o,
  output logic                          blk_store_o,
  output xact_pkg::err_code_t           err_code_o,
  output logic                          blk_device_idle_o,
  output logic                          usb_timeout_error_o
);
  import usb_pkg::*;
  import xact_pkg::*;

  bulk_state_t bulk_state;
  logic        dato_rx;
  logic        rx_last;
  logic        eop_rx;
  logic        ta_start;
  logic        ta_response;

  // OUT data goes to the sink only in DATO_RX, otherwise it is dropped
  assign dato_rx = bulk_state == DATO_RX;
  assign blk_rx_tvalid_o = dato_rx && usb_rx_tvalid_i;
  assign blk_rx_tlast_o = usb_rx_tlast_i;
  assign blk_rx_tkeep_o = usb_rx_tkeep_i;
  assign blk_rx_tdata_o = usb_rx_tdata_i;
  assign usb_rx_tready_o = dato_rx ? blk_rx_tready_i : 1'b1;
  assign rx_last = usb_rx_tvalid_i && usb_rx_tready_o && usb_rx_tlast_i;

  // Host turnaround starts after our data packet or our OUT handshake
  assign ta_start = usb_sent_i && usb_tuser_o.kind == CLS_DATA ||
                    hsk_sent_i && bulk_state == DATO_ACK;
  assign ta_response = tok_recv_i || hsk_recv_i || usb_recv_i;

  xact_control #(
    .BULK_ENDPOINT(BULK_ENDPOINT)
  ) i_xact_control (
    .*,
    .rx_last_i    (rx_last),
    .timeout_i    (usb_timeout_error_o),
    .bulk_state_o (bulk_state),
    .device_idle_o(blk_device_idle_o)
  );

  data_toggle #(
    .NUM_ENDPOINTS(NUM_ENDPOINTS)
  ) i_data_toggle (
    .*,
    .bulk_state_i (bulk_state),
    .eop_rx_i     (eop_rx),
    .hsk_pending_i(hsk_send_o)
  );

  eop_timer i_eop_timer (
    .*,
    .eop_rx_o(eop_rx),
    .eop_tx_o()
  );

  turnaround_timer #(
    .TURNAROUND_CYCLES(TURNAROUND_CYCLES)
  ) i_turnaround_timer (
    .clock        (clock),
    .reset        (reset),
    .start_i      (ta_start),
    .response_i   (ta_response),
    .device_idle_i(blk_device_idle_o),
    .timeout_o    (usb_timeout_error_o)
  );

  tx_stream_path i_tx_stream_path (
    .clock       (clock),
    .reset       (reset),
    .bulk_state_i(bulk_state),
    .blk_tvalid_i(blk_tx_tvalid_i),
    .blk_tlast_i (blk_tx_tlast_i),
    .blk_tkeep_i (blk_tx_tkeep_i),
    .blk_tdata_i (blk_tx_tdata_i),
    .blk_tready_o(blk_tx_tready_o),
    .usb_tvalid_o(usb_tx_tvalid_o),
    .usb_tready_i(usb_tx_tready_i),
    .usb_tlast_o (usb_tx_tlast_o),
    .usb_tkeep_o (usb_tx_tkeep_o),
    .usb_tdata_o (usb_tx_tdata_o)
  );

endmodule

`default_nettype wire

//--- tests/xact_tb.sv
`timescale 1ns/10ps
`default_nettype none

module xact_tb;
  import usb_pkg::*;
  import xact_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int TA_CYCLES = TURNAROUND_DEFAULT;
  localparam int BULK_EP = 1;
  localparam logic [ADDR_BITS-1:0] DEV_ADDR = 7'h2a;
  localparam int WAIT_LIMIT = 64;
  localparam int NUM_XACTS = 8;
  localparam int WATCHDOG_CYCLES = NUM_XACTS * (TA_CYCLES + 64);
  localparam int REPLY_ACK = 0;
  localparam int REPLY_NAK = 1;
  localparam int REPLY_NONE = 2;
  localparam logic [3:0] ACK_TUSER = {HSK_ACK, CLS_HSK};

  logic                 clock;
  logic                 reset;
  logic [ADDR_BITS-1:0] usb_addr_i;
  logic                 tok_recv_i;
  pid_t                 tok_pid_i;
  logic [ADDR_BITS-1:0] tok_addr_i;
  logic [ENDP_BITS-1:0] tok_endp_i;
  logic                 hsk_recv_i;
  pid_t                 hsk_pid_i;
  logic                 hsk_send_o;
  logic                 hsk_sent_i;
  logic                 usb_recv_i;
  logic                 usb_sent_i;
  tuser_t               usb_tuser_o;
  logic                 usb_rx_tvalid_i = 1'b0;
  logic                 usb_rx_tready_o;
  logic                 usb_rx_tlast_i = 1'b0;
  logic                 usb_rx_tkeep_i;
  logic [7:0]           usb_rx_tdata_i = 8'h00;
  logic                 usb_tx_tvalid_o;
  logic                 usb_tx_tready_i = 1'b0;
  logic                 usb_tx_tlast_o;
  logic                 usb_tx_tkeep_o;
  logic [7:0]           usb_tx_tdata_o;
  logic                 blk_rx_tvalid_o;
  logic                 blk_rx_tready_i = 1'b0;
  logic                 blk_rx_tlast_o;
  logic                 blk_rx_tkeep_o;
  logic [7:0]           blk_rx_tdata_o;
  logic                 blk_tx_tvalid_i = 1'b0;
  logic                 blk_tx_tready_o;
  logic                 blk_tx_tlast_i = 1'b0;
  logic                 blk_tx_tkeep_i;
  logic [7:0]           blk_tx_tdata_i = 8'h00;
  logic                 blk_in_ready_i;
  logic                 blk_out_ready_i;
  logic                 blk_start_o;
  logic                 blk_fetch_o;
  logic                 blk_store_o;
  err_code_t            err_code_o;
  logic                 blk_device_idle_o;
  logic                 usb_timeout_error_o;

  logic [15:0] lfsr_q = 16'd45710;
  logic [7:0]  src_q[$];
  logic [8:0]  rx_q[$];
  logic [9:0]  tx_exp_q[$];
  logic [8:0]  rx_exp_q[$];
  logic        tx_last_seen = 1'b0;
  int          tx_count = 0;
  logic [3:0]  exp_odd = '0;
  int          mismatches = 0;
  int          stalls = 0;

  xact_top i_xact_top (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Galois LFSR, one step per bit
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hb400 : 16'h0000);
      r = {r[6:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic report_stall(input string what);
    stalls++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  // PHY side: back-pressure, bulk source and OUT packet bytes
  always @(negedge clock) begin
    usb_tx_tready_i = rand_bits(2) != 8'h00;
    blk_rx_tready_i = rand_bits(2) != 8'h00;
    blk_tx_tvalid_i = src_q.size() != 0;
    blk_tx_tlast_i = src_q.size() == 1;
    blk_tx_tdata_i = src_q.size() != 0 ? src_q[0] : 8'h00;
    usb_rx_tvalid_i = rx_q.size() != 0;
    {usb_rx_tlast_i, usb_rx_tdata_i} = rx_q.size() != 0 ? rx_q[0] : 9'h000;
  end

  // Stream handshakes and data checks, seen with pre-edge values
  always @(posedge clock) begin
    if (blk_tx_tvalid_i && blk_tx_tready_o) begin
      void'(src_q.pop_front());
    end
    // OUT bytes are only offered while the sink is being fed
    if (!reset && usb_rx_tvalid_i) begin
      assert (blk_rx_tvalid_o && usb_rx_tready_o == blk_rx_tready_i)
      else report_mismatch("OUT stream not forwarded to the bulk sink");
    end
    if (usb_rx_tvalid_i && usb_rx_tready_o) begin
      void'(rx_q.pop_front());
    end
    if (!reset && usb_tx_tvalid_o && usb_tx_tready_i) begin
      tx_count++;
      tx_last_seen = tx_last_seen || usb_tx_tlast_o;
      assert (tx_exp_q.size() != 0 &&
              {usb_tx_tkeep_o, usb_tx_tlast_o, usb_tx_tdata_o} == tx_exp_q[0])
      else report_mismatch($sformatf("IN item %h, expected %h",
                                     {usb_tx_tkeep_o, usb_tx_tlast_o, usb_tx_tdata_o},
                                     tx_exp_q.size() != 0 ? tx_exp_q[0] : 10'h3ff));
      if (tx_exp_q.size() != 0) begin
        void'(tx_exp_q.pop_front());
      end
    end
    if (!reset && blk_rx_tvalid_o && blk_rx_tready_i) begin
      assert (rx_exp_q.size() != 0 && blk_rx_tkeep_o &&
              {blk_rx_tlast_o, blk_rx_tdata_o} == rx_exp_q[0])
      else report_mismatch($sformatf("OUT byte %h, expected %h",
                                     {blk_rx_tlast_o, blk_rx_tdata_o},
                                     rx_exp_q.size() != 0 ? rx_exp_q[0] : 9'h1ff));
      if (rx_exp_q.size() != 0) begin
        void'(rx_exp_q.pop_front());
      end
    end
  end

  reset_check: assert property (@(posedge clock)
    reset |=> !hsk_send_o && !blk_start_o && !blk_fetch_o && !blk_store_o &&
              !usb_tx_tvalid_o && !usb_timeout_error_o && err_code_o == ER_NONE)
  else report_mismatch("outputs not at their reset values");

  // Handshake request 7 cycles after the data packet starts, typed as ACK
  hsk_rise_check: assert property (@(posedge clock) disable iff (reset)
    usb_recv_i |-> ##7 ($rose(hsk_send_o) && usb_tuser_o == ACK_TUSER))
  else report_mismatch("handshake request not raised as ACK 7 cycles after usb_recv_i");

  hsk_fall_check: assert property (@(posedge clock) disable iff (reset)
    hsk_sent_i |=> !hsk_send_o)
  else report_mismatch("handshake request still high after hsk_sent_i");

  task automatic send_token(input pid_t pid, input logic [ADDR_BITS-1:0] addr, input int endp);
    @(negedge clock);
    tok_recv_i = 1'b1;
    tok_pid_i = pid;
    tok_addr_i = addr;
    tok_endp_i = ENDP_BITS'(endp);
    @(negedge clock);
    tok_recv_i = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!blk_device_idle_o && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!blk_device_idle_o) begin
      report_stall("the engine to return to idle");
    end
    repeat (4) @(negedge clock);
    assert (!usb_timeout_error_o) else report_mismatch("timeout still set when idle");
  endtask

  task automatic run_in(input int endp, input logic src_ready, input int nbytes, input int reply);
    int         n;
    logic [7:0] b;
    @(posedge clock);
    tx_last_seen = 1'b0;
    tx_count = 0;
    if (src_ready) begin
      for (int i = 0; i < nbytes; i++) begin
        b = rand_bits(8);
        src_q.push_back(b);
        tx_exp_q.push_back({1'b1, i == nbytes - 1, b});
      end
    end else begin
      // Zero-data packet
      tx_exp_q.push_back({1'b0, 1'b1, 8'h00});
    end
    @(negedge clock);
    blk_in_ready_i = src_ready;
    send_token(TOK_IN, DEV_ADDR, endp);
    assert (usb_tuser_o == {exp_odd[endp] ? DATA1 : DATA0, CLS_DATA})
    else report_mismatch($sformatf("IN packet type %h on endpoint %0d", usb_tuser_o, endp));
    assert (err_code_o == (endp == BULK_EP ? ER_NONE : ER_ENDP))
    else report_mismatch($sformatf("error code %h after IN token", err_code_o));
    n = 0;
    while (!tx_last_seen && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!tx_last_seen) begin
      report_stall("the last IN data item");
    end
    repeat (4) @(negedge clock);
    assert (tx_count == (src_ready ? nbytes : 1))
    else report_mismatch($sformatf("%0d IN items sent", tx_count));
    usb_sent_i = 1'b1;
    @(negedge clock);
    usb_sent_i = 1'b0;
    if (reply == REPLY_NONE) begin
      n = 1;
      while (!usb_timeout_error_o && n <= TA_CYCLES + 8) begin
        @(negedge clock);
        n++;
      end
      assert (usb_timeout_error_o && n <= TA_CYCLES + 2)
      else report_mismatch($sformatf("turnaround timeout after %0d cycles", n));
    end else begin
      hsk_pid_i = reply == REPLY_ACK ? HSK_ACK : HSK_NAK;
      hsk_recv_i = 1'b1;
      @(negedge clock);
      hsk_recv_i = 1'b0;
      if (reply == REPLY_ACK) begin
        exp_odd[endp] = ~exp_odd[endp];
      end
    end
    wait_idle();
  endtask

  task automatic run_out(input int endp, input int nbytes);
    int         n;
    logic [7:0] b;
    @(negedge clock);
    blk_out_ready_i = 1'b1;
    send_token(TOK_OUT, DEV_ADDR, endp);
    // Bytes only start once the bulk FSM is in DATO_RX
    @(posedge clock);
    for (int i = 0; i < nbytes; i++) begin
      b = rand_bits(8);
      rx_q.push_back({i == nbytes - 1, b});
      rx_exp_q.push_back({i == nbytes - 1, b});
    end
    @(negedge clock);
    usb_recv_i = 1'b1;
    @(negedge clock);
    usb_recv_i = 1'b0;
    n = 0;
    while (!(hsk_send_o && rx_exp_q.size() == 0) && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (!hsk_send_o || rx_exp_q.size() != 0) begin
      report_stall("the OUT bytes and the handshake request");
    end
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
    exp_odd[endp] = ~exp_odd[endp];
    wait_idle();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset = 1'b1;
    usb_addr_i = DEV_ADDR;
    tok_recv_i = 1'b0;
    tok_pid_i = TOK_SOF;
    tok_addr_i = '0;
    tok_endp_i = '0;
    hsk_recv_i = 1'b0;
    hsk_pid_i = HSK_ACK;
    hsk_sent_i = 1'b0;
    usb_recv_i = 1'b0;
    usb_sent_i = 1'b0;
    usb_rx_tkeep_i = 1'b1;
    blk_tx_tkeep_i = 1'b1;
    blk_in_ready_i = 1'b0;
    blk_out_ready_i = 1'b0;
    repeat (16) @(negedge clock);
    reset = 1'b0;

    // Token for another device
    send_token(TOK_IN, DEV_ADDR ^ 7'h01, BULK_EP);
    repeat (4) begin
      assert (!blk_start_o && blk_device_idle_o)
      else report_mismatch("token for another address started a transfer");
      @(negedge clock);
    end

    run_in(BULK_EP, 1'b1, 12, REPLY_ACK);
    run_in(BULK_EP, 1'b1, 7, REPLY_ACK);
    run_in(BULK_EP, 1'b0, 0, REPLY_ACK);
    run_out(BULK_EP, 9);
    run_in(BULK_EP, 1'b1, 4, REPLY_NONE);

    // Error codes last, DUMP holds until reset
    run_in(2, 1'b0, 0, REPLY_NAK);
    send_token(TOK_SETUP, DEV_ADDR, BULK_EP);
    repeat (4) begin
      assert (err_code_o == ER_TOKN && !blk_start_o)
      else report_mismatch($sformatf("error code %h after SETUP token", err_code_o));
      @(negedge clock);
    end

    $display("Mismatches: %0d, timeouts: %0d", mismatches, stalls);
    if (mismatches == 0 && stalls == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hdl/usb_pkg.sv
hdl/xact_pkg.sv
hdl/xact_control.sv
hdl/data_toggle.sv
hdl/eop_timer.sv
hdl/turnaround_timer.sv
hdl/tx_stream_path.sv
hdl/xact_top.sv
tests/xact_tb.sv
